// File: source/la_decode_consts.svh
`ifndef LA_DECODE_CONSTS_SVH
`define LA_DECODE_CONSTS_SVH

// 2RI16 format, opcode in bits 31..26
// {opcode[6], offs[16], rj[5], rd[5]}
`define EXE_JIRL        6'b010011
`define EXE_BEQ         6'b010110
`define EXE_BNE         6'b010111
`define EXE_BLT         6'b011000
`define EXE_BGE         6'b011001
`define EXE_BLTU        6'b011010
`define EXE_BGEU        6'b011011

// 2RI12 format, opcode in bits 31..22
// {opcode[10], si12[12], rj[5], rd[5]}
`define EXE_SLTI        10'b0000001000
`define EXE_SLTUI       10'b0000001001
`define EXE_ADDI_W      10'b0000001010
`define EXE_ANDI        10'b0000001101
`define EXE_ORI         10'b0000001110
`define EXE_XORI        10'b0000001111

// 3R format, opcode in bits 31..15
// {opcode[17], rk[5], rj[5], rd[5]}
`define EXE_ADD_W       17'b00000000000100000
`define EXE_SUB_W       17'b00000000000100010
`define EXE_SLT         17'b00000000000100100
`define EXE_SLTU        17'b00000000000100101
`define EXE_NOR         17'b00000000000101000
`define EXE_AND         17'b00000000000101001
`define EXE_OR          17'b00000000000101010
`define EXE_XOR         17'b00000000000101011

// alu operation codes, jump group
`define EXE_JIRL_OP     8'h40
`define EXE_BEQ_OP      8'h41
`define EXE_BNE_OP      8'h42
`define EXE_BLT_OP      8'h43
`define EXE_BGE_OP      8'h44
`define EXE_BLTU_OP     8'h45
`define EXE_BGEU_OP     8'h46

// immediate alu operations
`define EXE_ADDI_W_OP   8'h10
`define EXE_SLTI_OP     8'h11
`define EXE_SLTUI_OP    8'h12
`define EXE_ANDI_OP     8'h20
`define EXE_ORI_OP      8'h21
`define EXE_XORI_OP     8'h22

// register alu operations
`define EXE_ADD_W_OP    8'h18
`define EXE_SUB_W_OP    8'h19
`define EXE_SLT_OP      8'h1a
`define EXE_SLTU_OP     8'h1b
`define EXE_AND_OP      8'h28
`define EXE_OR_OP       8'h29
`define EXE_XOR_OP      8'h2a
`define EXE_NOR_OP      8'h2b

// result select, zero means nothing selected
`define RES_ARITH       3'b001
`define RES_LOGIC       3'b010
`define RES_JUMP        3'b011

`endif

// File: source/la_decode_pkg.sv
`default_nettype none

// shared types for the decode stage
package la_decode_pkg;

    // raw instruction word as fetched
    typedef logic [31:0] instr_t;

    // data path word, also used for immediates
    typedef logic [31:0] data_t;

    // general register index, 32 registers
    typedef logic [4:0] gpr_addr_t;

    // operation code handed to the ALU
    typedef logic [7:0] alu_op_t;

    // selects which execute unit result is written back
    typedef logic [2:0] alu_sel_t;

    // one decoded instruction
    // read port a carries rj, port b carries rk or rd
    typedef struct packed {
        // bit 0 is port a, bit 1 is port b
        logic [1:0] reg_read_valid;
        gpr_addr_t  reg_read_addr_a;
        gpr_addr_t  reg_read_addr_b;

        // imm replaces port b operand when set
        logic       use_imm;
        data_t      imm;

        // destination register
        logic       reg_write_valid;
        gpr_addr_t  reg_write_addr;

        // execute control
        alu_op_t    alu_op;
        alu_sel_t   alu_sel;

        // no format decoder recognized the word
        logic       illegal;
    } decode_result_t;

    // convenience for building sign-extended immediates
    function automatic data_t sext12(input logic [11:0] value);
        data_t ext;
        ext = {{20{value[11]}}, value};
        return ext;
    endfunction

    function automatic data_t zext12(input logic [11:0] value);
        data_t ext;
        ext = {20'b0, value};
        return ext;
    endfunction

    // branch offsets count words, so shift by two
    function automatic data_t sext16_sl2(input logic [15:0] value);
        data_t ext;
        ext = {{14{value[15]}}, value, 2'b00};
        return ext;
    endfunction

endpackage

`default_nettype wire

// File: source/decoder_2ri16.sv
`include "la_decode_consts.svh"

`default_nettype none

// branches and jirl
// {opcode[6], offs[16], rj[5], rd[5]}
module decoder_2ri16 (
    input  la_decode_pkg::instr_t         instr_i,
    output logic                          valid_o,
    output la_decode_pkg::decode_result_t result_o
);
    import la_decode_pkg::*;

    gpr_addr_t   rd;
    gpr_addr_t   rj;
    logic [15:0] offs16;
    logic [5:0]  opcode;
    alu_op_t     alu_op;
    logic        is_jirl;

    assign rd      = instr_i[4:0];
    assign rj      = instr_i[9:5];
    assign offs16  = instr_i[25:10];
    assign opcode  = instr_i[31:26];
    assign is_jirl = (opcode == `EXE_JIRL);

    // opcode lookup
    always_comb begin
        valid_o = 1'b1;
        alu_op  = '0;
        case (opcode)
            `EXE_JIRL: alu_op = `EXE_JIRL_OP;
            `EXE_BEQ:  alu_op = `EXE_BEQ_OP;
            `EXE_BNE:  alu_op = `EXE_BNE_OP;
            `EXE_BLT:  alu_op = `EXE_BLT_OP;
            `EXE_BGE:  alu_op = `EXE_BGE_OP;
            `EXE_BLTU: alu_op = `EXE_BLTU_OP;
            `EXE_BGEU: alu_op = `EXE_BGEU_OP;
            default:   valid_o = 1'b0;
        endcase
    end

    // field assembly, all zero when not ours
    always_comb begin
        result_o = '0;
        if (valid_o) begin
            // offset goes to the branch unit, not the alu operand
            result_o.use_imm = 1'b0;
            result_o.imm     = sext16_sl2(offs16);
            result_o.alu_op  = alu_op;
            result_o.alu_sel = `RES_JUMP;

            result_o.reg_read_addr_a = rj;
            if (is_jirl) begin
                // link register write, target from rj
                result_o.reg_read_valid  = 2'b01;
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = rd;
            end else begin
                // compare rj against rd
                result_o.reg_read_valid  = 2'b11;
                result_o.reg_read_addr_b = rd;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/decoder_2ri12.sv
`include "la_decode_consts.svh"

`default_nettype none

// immediate alu operations
// {opcode[10], si12[12], rj[5], rd[5]}
module decoder_2ri12 (
    input  la_decode_pkg::instr_t         instr_i,
    output logic                          valid_o,
    output la_decode_pkg::decode_result_t result_o
);
    import la_decode_pkg::*;

    gpr_addr_t   rd;
    gpr_addr_t   rj;
    logic [11:0] imm12;
    logic [9:0]  opcode;
    alu_op_t     alu_op;
    alu_sel_t    alu_sel;
    logic        sign_ext;

    assign rd     = instr_i[4:0];
    assign rj     = instr_i[9:5];
    assign imm12  = instr_i[21:10];
    assign opcode = instr_i[31:22];

    // arithmetic ops sign-extend, logic ops zero-extend
    always_comb begin
        valid_o  = 1'b1;
        alu_op   = '0;
        alu_sel  = `RES_ARITH;
        sign_ext = 1'b1;
        case (opcode)
            `EXE_ADDI_W: alu_op = `EXE_ADDI_W_OP;
            `EXE_SLTI:   alu_op = `EXE_SLTI_OP;
            `EXE_SLTUI:  alu_op = `EXE_SLTUI_OP;
            `EXE_ANDI: begin
                alu_op   = `EXE_ANDI_OP;
                alu_sel  = `RES_LOGIC;
                sign_ext = 1'b0;
            end
            `EXE_ORI: begin
                alu_op   = `EXE_ORI_OP;
                alu_sel  = `RES_LOGIC;
                sign_ext = 1'b0;
            end
            `EXE_XORI: begin
                alu_op   = `EXE_XORI_OP;
                alu_sel  = `RES_LOGIC;
                sign_ext = 1'b0;
            end
            default: valid_o = 1'b0;
        endcase
    end

    always_comb begin
        result_o = '0;
        if (valid_o) begin
            result_o.reg_read_valid  = 2'b01;
            result_o.reg_read_addr_a = rj;
            result_o.use_imm         = 1'b1;
            result_o.imm             = sign_ext ? sext12(imm12) : zext12(imm12);
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.alu_op          = alu_op;
            result_o.alu_sel         = alu_sel;
        end
    end

endmodule

`default_nettype wire

// File: source/decoder_3r.sv
`include "la_decode_consts.svh"

`default_nettype none

// register-register alu operations
// {opcode[17], rk[5], rj[5], rd[5]}
module decoder_3r (
    input  la_decode_pkg::instr_t         instr_i,
    output logic                          valid_o,
    output la_decode_pkg::decode_result_t result_o
);
    import la_decode_pkg::*;

    gpr_addr_t   rd;
    gpr_addr_t   rj;
    gpr_addr_t   rk;
    logic [16:0] opcode;
    alu_op_t     alu_op;
    alu_sel_t    alu_sel;

    assign rd     = instr_i[4:0];
    assign rj     = instr_i[9:5];
    assign rk     = instr_i[14:10];
    assign opcode = instr_i[31:15];

    always_comb begin
        valid_o = 1'b1;
        alu_op  = '0;
        alu_sel = `RES_LOGIC;
        case (opcode)
            `EXE_ADD_W: begin
                alu_op  = `EXE_ADD_W_OP;
                alu_sel = `RES_ARITH;
            end
            `EXE_SUB_W: begin
                alu_op  = `EXE_SUB_W_OP;
                alu_sel = `RES_ARITH;
            end
            `EXE_SLT: begin
                alu_op  = `EXE_SLT_OP;
                alu_sel = `RES_ARITH;
            end
            `EXE_SLTU: begin
                alu_op  = `EXE_SLTU_OP;
                alu_sel = `RES_ARITH;
            end
            `EXE_AND: alu_op = `EXE_AND_OP;
            `EXE_OR:  alu_op = `EXE_OR_OP;
            `EXE_XOR: alu_op = `EXE_XOR_OP;
            `EXE_NOR: alu_op = `EXE_NOR_OP;
            default:  valid_o = 1'b0;
        endcase
    end

    // both ports read, imm stays zero
    always_comb begin
        result_o = '0;
        if (valid_o) begin
            result_o.reg_read_valid  = 2'b11;
            result_o.reg_read_addr_a = rj;
            result_o.reg_read_addr_b = rk;
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.alu_op          = alu_op;
            result_o.alu_sel         = alu_sel;
        end
    end

endmodule

`default_nettype wire

// File: source/la_decode_top.sv
`default_nettype none

// decode stage
// three format decoders in parallel, one output register
module la_decode_top (
    input  logic                          clk_i,
    input  logic                          arst_n_i,

    // upstream, held while stalled
    input  logic                          instr_valid_i,
    input  la_decode_pkg::instr_t         instr_i,

    // downstream back-pressure
    input  logic                          stall_i,

    output logic                          decoded_valid_o,
    output la_decode_pkg::decode_result_t decoded_o
);
    import la_decode_pkg::*;

    logic           vld_2ri16;
    logic           vld_2ri12;
    logic           vld_3r;
    logic           any_valid;
    decode_result_t res_2ri16;
    decode_result_t res_2ri12;
    decode_result_t res_3r;
    decode_result_t merged;

    decoder_2ri16 u_dec_2ri16 (
        .instr_i  (instr_i),
        .valid_o  (vld_2ri16),
        .result_o (res_2ri16)
    );

    decoder_2ri12 u_dec_2ri12 (
        .instr_i  (instr_i),
        .valid_o  (vld_2ri12),
        .result_o (res_2ri12)
    );

    decoder_3r u_dec_3r (
        .instr_i  (instr_i),
        .valid_o  (vld_3r),
        .result_o (res_3r)
    );

    assign any_valid = vld_2ri16 | vld_2ri12 | vld_3r;

    // idle decoders drive zero, so OR picks the one hit
    always_comb begin
        merged = decode_result_t'(res_2ri16 | res_2ri12 | res_3r);
        if (instr_valid_i && !any_valid) begin
            merged         = '0;
            merged.illegal = 1'b1;
        end
    end

    // pipeline register, frozen while stalled
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            decoded_valid_o <= 1'b0;
            decoded_o       <= '0;
        end else if (!stall_i) begin
            decoded_valid_o <= instr_valid_i;
            decoded_o       <= merged;
        end
    end

    // opcode spaces of the three formats must not overlap
    a_onehot_decoders: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({vld_2ri16, vld_2ri12, vld_3r})
    );

    // held output must not change under stall
    a_stall_holds: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (stall_i && decoded_valid_o) |=> ($stable(decoded_o) && decoded_valid_o)
    );

    // illegal only ever reported for a real instruction
    a_illegal_has_valid: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        decoded_o.illegal |-> decoded_valid_o
    );

endmodule

`default_nettype wire

// File: verif/tb_la_decode.sv
`include "la_decode_consts.svh"

`default_nettype none

module tb_la_decode;
    timeunit 1ns;
    timeprecision 1ps;

    import la_decode_pkg::*;

    // about four times the cycles the directed tests need
    localparam int TIMEOUT_CYCLES = 400;

    logic           clk_i;
    logic           arst_n_i;
    logic           instr_valid_i;
    instr_t         instr_i;
    logic           stall_i;
    logic           decoded_valid_o;
    decode_result_t decoded_o;

    int             error_count;
    int             check_count;
    int             cycle_count;
    logic [31:0]    seed_value;

    la_decode_top dut0 (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .stall_i         (stall_i),
        .decoded_valid_o (decoded_valid_o),
        .decoded_o       (decoded_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        cycle_count = 0;
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, run stopped after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic drive_inputs(input logic valid, input instr_t word, input logic stall);
        @(posedge clk_i);
        instr_valid_i <= valid;
        instr_i       <= word;
        stall_i       <= stall;
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_output(input logic exp_valid, input decode_result_t exp,
                                input logic with_fields);
        compare_field("decoded_valid_o", 32'(decoded_valid_o), 32'(exp_valid));
        if (with_fields) begin
            compare_field("decoded_o.reg_read_valid", 32'(decoded_o.reg_read_valid),
                          32'(exp.reg_read_valid));
            compare_field("decoded_o.reg_read_addr_a", 32'(decoded_o.reg_read_addr_a),
                          32'(exp.reg_read_addr_a));
            compare_field("decoded_o.reg_read_addr_b", 32'(decoded_o.reg_read_addr_b),
                          32'(exp.reg_read_addr_b));
            compare_field("decoded_o.use_imm", 32'(decoded_o.use_imm), 32'(exp.use_imm));
            compare_field("decoded_o.imm", decoded_o.imm, exp.imm);
            compare_field("decoded_o.reg_write_valid", 32'(decoded_o.reg_write_valid),
                          32'(exp.reg_write_valid));
            compare_field("decoded_o.reg_write_addr", 32'(decoded_o.reg_write_addr),
                          32'(exp.reg_write_addr));
            compare_field("decoded_o.alu_op", 32'(decoded_o.alu_op), 32'(exp.alu_op));
            compare_field("decoded_o.alu_sel", 32'(decoded_o.alu_sel), 32'(exp.alu_sel));
            compare_field("decoded_o.illegal", 32'(decoded_o.illegal), 32'(exp.illegal));
        end
    endtask

    // present one word, check it after the register stage
    task automatic apply_and_check(input instr_t word, input decode_result_t exp);
        drive_inputs(1'b1, word, 1'b0);
        @(posedge clk_i);
        @(negedge clk_i);
        check_output(1'b1, exp, 1'b1);
    endtask

    function automatic decode_result_t expect_3r(input alu_op_t aop, input alu_sel_t sel,
                                                 input gpr_addr_t rd, input gpr_addr_t rj,
                                                 input gpr_addr_t rk);
        decode_result_t exp;
        exp                 = '0;
        exp.reg_read_valid  = 2'b11;
        exp.reg_read_addr_a = rj;
        exp.reg_read_addr_b = rk;
        exp.reg_write_valid = 1'b1;
        exp.reg_write_addr  = rd;
        exp.alu_op          = aop;
        exp.alu_sel         = sel;
        return exp;
    endfunction

    task automatic branch_case(input logic [5:0] opcode, input alu_op_t aop,
                               input logic is_jirl);
        decode_result_t exp;
        gpr_addr_t      rd;
        gpr_addr_t      rj;
        logic [15:0]    offs;
        for (int n = 0; n < 2; n++) begin
            rd       = gpr_addr_t'($urandom);
            rj       = gpr_addr_t'($urandom);
            offs     = 16'($urandom);
            // second round is a backward target
            offs[15] = (n == 1);
            exp                 = '0;
            exp.reg_read_valid  = is_jirl ? 2'b01 : 2'b11;
            exp.reg_read_addr_a = rj;
            exp.reg_read_addr_b = is_jirl ? 5'd0 : rd;
            exp.imm             = data_t'(int'($signed(offs)) * 4);
            exp.reg_write_valid = is_jirl;
            exp.reg_write_addr  = is_jirl ? rd : 5'd0;
            exp.alu_op          = aop;
            exp.alu_sel         = `RES_JUMP;
            apply_and_check({opcode, offs, rj, rd}, exp);
        end
    endtask

    task automatic imm_alu_case(input logic [9:0] opcode, input alu_op_t aop,
                                input logic is_logic);
        decode_result_t exp;
        gpr_addr_t      rd;
        gpr_addr_t      rj;
        logic [11:0]    imm12;
        for (int n = 0; n < 2; n++) begin
            rd        = gpr_addr_t'($urandom);
            rj        = gpr_addr_t'($urandom);
            imm12     = 12'($urandom);
            imm12[11] = (n == 1);
            exp                 = '0;
            exp.reg_read_valid  = 2'b01;
            exp.reg_read_addr_a = rj;
            exp.use_imm         = 1'b1;
            exp.imm             = is_logic ? {20'h0, imm12} : data_t'(int'($signed(imm12)));
            exp.reg_write_valid = 1'b1;
            exp.reg_write_addr  = rd;
            exp.alu_op          = aop;
            exp.alu_sel         = is_logic ? `RES_LOGIC : `RES_ARITH;
            apply_and_check({opcode, imm12, rj, rd}, exp);
        end
    endtask

    task automatic reg_alu_case(input logic [16:0] opcode, input alu_op_t aop,
                                input alu_sel_t sel);
        gpr_addr_t rd;
        gpr_addr_t rj;
        gpr_addr_t rk;
        rd = gpr_addr_t'($urandom);
        rj = gpr_addr_t'($urandom);
        rk = gpr_addr_t'($urandom);
        apply_and_check({opcode, rk, rj, rd}, expect_3r(aop, sel, rd, rj, rk));
    endtask

    task automatic reset_and_latency();
        decode_result_t exp;
        exp = expect_3r(`EXE_ADD_W_OP, `RES_ARITH, 5'd3, 5'd7, 5'd12);
        @(negedge clk_i);
        check_output(1'b0, '0, 1'b1);
        drive_inputs(1'b1, {`EXE_ADD_W, 5'd12, 5'd7, 5'd3}, 1'b0);
        // not sampled yet
        @(negedge clk_i);
        check_output(1'b0, '0, 1'b0);
        @(posedge clk_i);
        @(negedge clk_i);
        check_output(1'b1, exp, 1'b1);
    endtask

    task automatic illegal_and_idle();
        decode_result_t exp;
        exp         = '0;
        exp.illegal = 1'b1;
        apply_and_check(32'hffff_ffff, exp);
        drive_inputs(1'b0, '0, 1'b0);
        @(posedge clk_i);
        @(negedge clk_i);
        check_output(1'b0, '0, 1'b0);
    endtask

    task automatic stall_hold();
        decode_result_t exp_a;
        decode_result_t exp_c;
        exp_a = expect_3r(`EXE_SUB_W_OP, `RES_ARITH, 5'd1, 5'd2, 5'd3);
        exp_c = expect_3r(`EXE_XOR_OP, `RES_LOGIC, 5'd30, 5'd29, 5'd28);
        drive_inputs(1'b1, {`EXE_SUB_W, 5'd3, 5'd2, 5'd1}, 1'b0);
        drive_inputs(1'b1, $urandom, 1'b1);
        @(negedge clk_i);
        check_output(1'b1, exp_a, 1'b1);
        // input keeps changing under stall
        for (int n = 0; n < 3; n++) begin
            drive_inputs(1'b1, $urandom, 1'b1);
            @(negedge clk_i);
            check_output(1'b1, exp_a, 1'b1);
        end
        drive_inputs(1'b1, {`EXE_XOR, 5'd28, 5'd29, 5'd30}, 1'b1);
        @(negedge clk_i);
        check_output(1'b1, exp_a, 1'b1);
        drive_inputs(1'b1, {`EXE_XOR, 5'd28, 5'd29, 5'd30}, 1'b0);
        @(negedge clk_i);
        check_output(1'b1, exp_a, 1'b1);
        @(posedge clk_i);
        @(negedge clk_i);
        check_output(1'b1, exp_c, 1'b1);
    endtask

    task automatic back_to_back();
        instr_t         words [3];
        decode_result_t exps [3];
        words[0] = {`EXE_SLT, 5'd4, 5'd5, 5'd6};
        words[1] = {`EXE_AND, 5'd7, 5'd8, 5'd9};
        words[2] = {`EXE_NOR, 5'd10, 5'd11, 5'd31};
        exps[0]  = expect_3r(`EXE_SLT_OP, `RES_ARITH, 5'd6, 5'd5, 5'd4);
        exps[1]  = expect_3r(`EXE_AND_OP, `RES_LOGIC, 5'd9, 5'd8, 5'd7);
        exps[2]  = expect_3r(`EXE_NOR_OP, `RES_LOGIC, 5'd31, 5'd11, 5'd10);
        for (int n = 0; n < 3; n++) begin
            drive_inputs(1'b1, words[n], 1'b0);
            if (n > 0) begin
                @(negedge clk_i);
                check_output(1'b1, exps[n-1], 1'b1);
            end
        end
        drive_inputs(1'b0, '0, 1'b0);
        @(negedge clk_i);
        check_output(1'b1, exps[2], 1'b1);
    endtask

    initial begin
        seed_value    = $urandom(32'h5b51);
        error_count   = 0;
        check_count   = 0;
        // a live instruction during reset must stay off the output
        arst_n_i      <= 1'b0;
        instr_valid_i <= 1'b1;
        instr_i       <= {`EXE_ORI, 12'hf0f, 5'd17, 5'd22};
        stall_i       <= 1'b0;
        repeat (2) @(posedge clk_i);
        arst_n_i      <= 1'b1;
        instr_valid_i <= 1'b0;
        instr_i       <= '0;

        reset_and_latency();
        branch_case(`EXE_JIRL, `EXE_JIRL_OP, 1'b1);
        branch_case(`EXE_BEQ, `EXE_BEQ_OP, 1'b0);
        branch_case(`EXE_BNE, `EXE_BNE_OP, 1'b0);
        branch_case(`EXE_BLT, `EXE_BLT_OP, 1'b0);
        branch_case(`EXE_BGE, `EXE_BGE_OP, 1'b0);
        branch_case(`EXE_BLTU, `EXE_BLTU_OP, 1'b0);
        branch_case(`EXE_BGEU, `EXE_BGEU_OP, 1'b0);
        imm_alu_case(`EXE_ADDI_W, `EXE_ADDI_W_OP, 1'b0);
        imm_alu_case(`EXE_SLTI, `EXE_SLTI_OP, 1'b0);
        imm_alu_case(`EXE_SLTUI, `EXE_SLTUI_OP, 1'b0);
        imm_alu_case(`EXE_ANDI, `EXE_ANDI_OP, 1'b1);
        imm_alu_case(`EXE_ORI, `EXE_ORI_OP, 1'b1);
        imm_alu_case(`EXE_XORI, `EXE_XORI_OP, 1'b1);
        reg_alu_case(`EXE_ADD_W, `EXE_ADD_W_OP, `RES_ARITH);
        reg_alu_case(`EXE_SUB_W, `EXE_SUB_W_OP, `RES_ARITH);
        reg_alu_case(`EXE_SLT, `EXE_SLT_OP, `RES_ARITH);
        reg_alu_case(`EXE_SLTU, `EXE_SLTU_OP, `RES_ARITH);
        reg_alu_case(`EXE_AND, `EXE_AND_OP, `RES_LOGIC);
        reg_alu_case(`EXE_OR, `EXE_OR_OP, `RES_LOGIC);
        reg_alu_case(`EXE_XOR, `EXE_XOR_OP, `RES_LOGIC);
        reg_alu_case(`EXE_NOR, `EXE_NOR_OP, `RES_LOGIC);
        illegal_and_idle();
        stall_hold();
        back_to_back();

        $display("checks=%0d errors=%0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: la_decode.f
+incdir+source
source/la_decode_pkg.sv
source/decoder_2ri16.sv
source/decoder_2ri12.sv
source/decoder_3r.sv
source/la_decode_top.sv
verif/tb_la_decode.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f la_decode.f --top-module tb_la_decode -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^Simulation PASSED$'; then
    exit 0
fi
exit 1
